// ==== compile.f ====
hdl/lsu_pkg.sv
hdl/lsu_request.sv
hdl/lsu_txn_ctrl.sv
hdl/lsu_load_align.sv
hdl/load_store_unit.sv
verification/lsu_txn_ctrl_sva.sv
verification/load_store_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module load_store_unit_tb \
  -o lsu_sim

# a failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/lsu_sim

// ==== verification/load_store_unit_tb.sv ====
/*
 * load/store unit testbench
 */

module load_store_unit_tb;

  import lsu_pkg::*;

  typedef struct {
    logic       we;
    data_type_e dt;
    sign_ext_e  se;
    word_t      wdata;
    logic [1:0] roff;       // register byte offset
    word_t      a;
    word_t      b;
    logic       useincr;
    int         gdelay;     // cycles before grant
    logic       mis;        // expected split
  } entry_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       data_req_ex_i;
  logic       data_we_ex_i;
  logic       addr_useincr_ex_i;
  logic       data_misaligned_ex_i;
  data_type_e data_type_ex_i;
  sign_ext_e  data_sign_ext_ex_i;
  word_t      data_wdata_ex_i;
  word_t      operand_a_ex_i;
  word_t      operand_b_ex_i;
  logic [1:0] data_reg_offset_ex_i;
  word_t      data_rdata_ex_o;
  word_t      data_addr_o;
  word_t      data_wdata_o;
  word_t      data_rdata_i;
  logic       data_misaligned_o;
  logic       lsu_ready_ex_o;
  logic       lsu_ready_wb_o;
  logic       busy_o;
  logic       data_req_o;
  logic       data_we_o;
  logic       data_gnt_i;
  logic       data_rvalid_i;
  be_t        data_be_o;

  word_t  mem [16];      // 64-byte memory model
  int     gnt_delay = 0;
  entry_t tbl [$];

  load_store_unit load_store_unit_i (.*);

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////
  // memory responder with grant after gnt_delay and rvalid one cycle later
  ////////////////////////////////////////////////////

  initial begin
    bit         accepted;
    int         wait_cnt;
    word_t      resp_word;
    logic [3:0] idx;
    accepted  = 1'b0;
    wait_cnt  = 0;
    resp_word = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    void'($urandom(32'h302f_a9fb));
    for (int i = 0; i < 16; i++) mem[i] = $urandom;
    forever begin
      @(posedge clk);
      #3;
      data_rvalid_i = accepted;
      data_rdata_i  = accepted ? resp_word : '0;
      data_gnt_i    = data_req_o && (wait_cnt >= gnt_delay);
      #5;                                       // bus lines settled by mid cycle
      accepted = data_req_o && data_gnt_i;
      if (accepted) begin
        idx       = data_addr_o[5:2];
        resp_word = mem[idx];
        if (data_we_o) begin
          for (int i = 0; i < 4; i++)
            if (data_be_o[i]) mem[idx][8*i +: 8] = data_wdata_o[8*i +: 8];
        end
        wait_cnt = 0;
      end else if (data_req_o) begin
        wait_cnt++;                             // stalled request
      end else begin
        wait_cnt = 0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////

  function automatic word_t ref_addr(entry_t e);
    return e.useincr ? e.a + e.b : e.a;
  endfunction

  function automatic be_t ref_be(entry_t e, bit second);
    be_t b;
    int  off;
    off = int'(ref_addr(e) & 32'h3);
    for (int i = 0; i < 4; i++) begin
      if (second) b[i] = (e.dt == DT_WORD) ? (i < off) : (i == 0);
      else if (e.dt == DT_WORD) b[i] = (i >= off);
      else if (e.dt == DT_HALF) b[i] = (i == off) || (i == off + 1);
      else b[i] = (i == off);
    end
    return b;
  endfunction

  function automatic word_t ref_wdata(entry_t e);
    logic [63:0] t;
    int          r;
    r = (int'(ref_addr(e) & 32'h3) - int'(e.roff)) & 3;
    t = {e.wdata, e.wdata} << (8 * r);         // byte rotate left
    return t[63:32];
  endfunction

  function automatic word_t ref_ext(word_t v, int nbits, sign_ext_e m);
    word_t upper;
    upper = ~((32'h1 << nbits) - 32'h1);
    if (m == SE_ONES || ((m == SE_SIGN || m == SE_SIGN_ALT) && v[nbits-1])) return v | upper;
    return v & ~upper;
  endfunction

  // bytes from addr upward across two consecutive words
  function automatic word_t ref_load(entry_t e);
    logic [63:0] pair;
    int          idx;
    idx  = int'((ref_addr(e) >> 2) & 32'hf);
    pair = {mem[(idx + 1) % 16], mem[idx]} >> (8 * int'(ref_addr(e) & 32'h3));
    if (e.dt == DT_WORD) return pair[31:0];
    if (e.dt == DT_HALF) return ref_ext(pair[31:0], 16, e.se);
    return ref_ext(pair[31:0], 8, e.se);
  endfunction

  ////////////////////////////////////////////////////
  // compare tasks and waits
  ////////////////////////////////////////////////////

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at time %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_be(input be_t got, input be_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at time %0t: %s, got %b expected %b", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "byte enable mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at time %0t: %s, got %b expected %b", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  // stall cycles must hold the request and keep EX waiting
  task automatic wait_grant(input word_t exp_addr);
    int n;
    n = 0;
    while (!data_gnt_i) begin
      check_bit(data_req_o, 1'b1, "request held");
      check_word(data_addr_o, exp_addr, "address held");
      check_bit(lsu_ready_ex_o, 1'b0, "EX stalled");
      check_bit(busy_o, 1'b1, "busy in stall");
      if (n == 50) begin
        $display("Verification failed");
        $fatal(1, "no grant from the memory model within 50 cycles");
      end
      @(posedge clk);
      #5;
      n++;
    end
  endtask

  task automatic wait_rvalid();
    int n;
    n = 0;
    while (!data_rvalid_i) begin
      if (n == 50) begin
        $display("Verification failed");
        $fatal(1, "no read response within 50 cycles");
      end
      @(posedge clk);
      #5;
      n++;
    end
  endtask

  task automatic drive(input entry_t e, input logic second);
    data_req_ex_i        = 1'b1;
    data_we_ex_i         = e.we;
    data_type_ex_i       = e.dt;
    data_sign_ext_ex_i   = e.se;
    data_wdata_ex_i      = e.wdata;
    data_reg_offset_ex_i = e.roff;
    operand_a_ex_i       = e.a;
    operand_b_ex_i       = e.b;
    addr_useincr_ex_i    = e.useincr;
    data_misaligned_ex_i = second;
  endtask

  task automatic drive_idle();
    data_req_ex_i        = 1'b0;
    data_misaligned_ex_i = 1'b0;
  endtask

  function automatic entry_t mk(logic we, data_type_e dt, sign_ext_e se, word_t wd,
                                logic [1:0] roff, word_t a, word_t b, logic inc,
                                int gd, logic mis);
    entry_t e;
    e = '{we, dt, se, wd, roff, a, b, inc, gd, mis};
    return e;
  endfunction

  // one access in two phases when it crosses a word
  task automatic run_entry(input entry_t e);
    entry_t e2;
    word_t  exp_res;
    exp_res   = ref_load(e);
    gnt_delay = e.gdelay;
    @(posedge clk);
    #2 drive(e, 1'b0);
    #3;
    check_word(data_addr_o, ref_addr(e), "address");
    check_be(data_be_o, ref_be(e, 1'b0), "byte enables");
    check_bit(data_misaligned_o, e.mis, "misaligned flag");
    check_bit(data_we_o, e.we, "write enable");
    if (e.we) check_word(data_wdata_o, ref_wdata(e), "write data");
    wait_grant(ref_addr(e));
    if (e.mis) begin
      e2 = e;
      if (e.useincr) e2.b = e.b + 32'd4;
      else e2.a = e.a + 32'd4;
      @(posedge clk);
      #2 drive(e2, 1'b1);
      #3;
      check_word(data_addr_o, (ref_addr(e) + 32'd4) & ~32'h3, "second phase address");
      check_be(data_be_o, ref_be(e, 1'b1), "second phase byte enables");
      check_bit(data_misaligned_o, 1'b0, "no split in second phase");
      if (e.we) check_word(data_wdata_o, ref_wdata(e), "second phase write data");
      wait_grant((ref_addr(e) + 32'd4) & ~32'h3);
    end
    @(posedge clk);
    #2 drive_idle();
    #3;
    wait_rvalid();
    check_bit(lsu_ready_wb_o, 1'b1, "WB ready with response");
    check_bit(busy_o, 1'b1, "busy until response");
    if (!e.we) check_word(data_rdata_ex_o, exp_res, "load result");
    @(posedge clk);
    #5;
    check_bit(data_rvalid_i, 1'b0, "single response per grant");
    check_bit(busy_o, 1'b0, "idle after response");
  endtask

  ////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////

  initial begin
    entry_t e1;
    entry_t e2;
    word_t  r1;
    word_t  r2;
    rst_n = 1'b0;
    data_type_ex_i = DT_WORD;
    data_sign_ext_ex_i = SE_ZERO;
    data_wdata_ex_i = '0;
    data_reg_offset_ex_i = 2'b00;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    data_we_ex_i = 1'b0;
    addr_useincr_ex_i = 1'b0;
    drive_idle();

    // stores first and then loads that read them back
    tbl.push_back(mk(1, DT_WORD, SE_ZERO, 32'hdead_beef, 0, 32'h10, 0, 0, 0, 0));
    tbl.push_back(mk(1, DT_HALF, SE_ZERO, 32'h1234_5678, 2, 32'h20, 2, 1, 1, 0));
    tbl.push_back(mk(1, DT_HALF, SE_ZERO, 32'h0000_a5c3, 0, 32'h24, 1, 1, 0, 0));
    tbl.push_back(mk(1, DT_BYTE, SE_ZERO, 32'h0000_0081, 0, 32'h30, 0, 0, 0, 0));
    tbl.push_back(mk(1, DT_BYTE, SE_ZERO, 32'h0000_7f00, 1, 32'h2f, 2, 1, 0, 0));
    tbl.push_back(mk(1, DT_BYTE_ALT, SE_ZERO, 32'hc000_0000, 3, 32'h32, 0, 0, 2, 0));
    tbl.push_back(mk(1, DT_BYTE, SE_ZERO, 32'h00e4_0000, 2, 32'h33, 0, 0, 0, 0));
    tbl.push_back(mk(1, DT_WORD, SE_ZERO, 32'hcafe_f00d, 0, 32'h35, 0, 0, 0, 1));
    tbl.push_back(mk(1, DT_HALF, SE_ZERO, 32'h0000_9abc, 1, 32'h38, 3, 1, 1, 1));
    for (int off = 0; off < 4; off++)
      for (int m = 0; m < 4; m++)
        tbl.push_back(mk(0, DT_BYTE, sign_ext_e'(m), '0, 0, word_t'(32'h30 + off), 0, 0,
                         m % 2, 0));
    for (int off = 0; off < 3; off++)
      for (int m = 0; m < 4; m++)
        tbl.push_back(mk(0, DT_HALF, sign_ext_e'(m), '0, 0, word_t'(32'h20 + off), 0, 0,
                         0, 0));
    tbl.push_back(mk(0, DT_WORD, SE_ZERO, '0, 0, 32'h10, 0, 0, 0, 0));
    tbl.push_back(mk(0, DT_WORD, SE_ZERO, '0, 0, 32'h31, 0, 0, 0, 1));
    tbl.push_back(mk(0, DT_WORD, SE_ZERO, '0, 0, 32'h30, 2, 1, 1, 1));
    tbl.push_back(mk(0, DT_WORD, SE_ZERO, '0, 0, 32'h37, 0, 0, 0, 1));
    tbl.push_back(mk(0, DT_HALF, SE_SIGN, '0, 0, 32'h3b, 0, 0, 0, 1));
    tbl.push_back(mk(0, DT_HALF, SE_ONES, '0, 0, 32'h20, 3, 1, 2, 1));
    // back-pressure with the grant withheld
    tbl.push_back(mk(0, DT_WORD, SE_ZERO, '0, 0, 32'h08, 0, 0, 4, 0));
    tbl.push_back(mk(0, DT_BYTE, SE_SIGN, '0, 0, 32'h0c, 1, 1, 3, 0));

    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;
    #3;
    check_bit(data_req_o, 1'b0, "no request after reset");
    check_bit(busy_o, 1'b0, "idle after reset");
    check_bit(lsu_ready_ex_o, 1'b1, "EX ready after reset");
    check_bit(lsu_ready_wb_o, 1'b1, "WB ready after reset");

    foreach (tbl[i]) run_entry(tbl[i]);

    // second load accepted in the cycle of the first response
    e1 = mk(0, DT_WORD, SE_ZERO, '0, 0, 32'h00, 0, 0, 0, 0);
    e2 = mk(0, DT_WORD, SE_ZERO, '0, 0, 32'h04, 0, 0, 0, 0);
    r1 = ref_load(e1);
    r2 = ref_load(e2);
    gnt_delay = 0;
    @(posedge clk);
    #2 drive(e1, 1'b0);
    #3 wait_grant(32'h00);
    @(posedge clk);
    #2 drive(e2, 1'b0);
    #3;
    check_bit(data_rvalid_i, 1'b1, "first response");
    check_bit(data_gnt_i, 1'b1, "second grant");
    check_bit(lsu_ready_ex_o, 1'b1, "accept during response");
    check_bit(lsu_ready_wb_o, 1'b1, "WB ready with first response");
    check_bit(busy_o, 1'b1, "busy with two in flight");
    check_word(data_rdata_ex_o, r1, "first back-to-back load");
    @(posedge clk);
    #2 drive_idle();
    #3 wait_rvalid();
    check_word(data_rdata_ex_o, r2, "second back-to-back load");

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== verification/lsu_txn_ctrl_sva.sv ====
/*
 * transaction control assertions
 */

module lsu_txn_ctrl_sva #(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned CNT_W = 2
) (
  input logic             clk,
  input logic             rst_n,
  input logic [CNT_W-1:0] cnt_q,
  input logic             trans_valid_o,
  input logic             gnt_i,
  input logic             rvalid_i
);

  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(DEPTH);

  // count stays within the outstanding limit
  count_in_range: assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= LIMIT)
    else $error("outstanding count above limit");

  // a response needs something in flight
  no_orphan_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (cnt_q != '0))
    else $error("rvalid with no access outstanding");

  // request is held until the bus grants it
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (trans_valid_o && !gnt_i) |=> trans_valid_o)
    else $error("request dropped before grant");

endmodule

bind lsu_txn_ctrl lsu_txn_ctrl_sva #(
  .DEPTH (DEPTH),
  .CNT_W (CNT_W)
) lsu_txn_ctrl_sva_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .cnt_q         (cnt_q),
  .trans_valid_o (trans_valid_o),
  .gnt_i         (gnt_i),
  .rvalid_i      (rvalid_i)
);

// ==== hdl/load_store_unit.sv ====
/*
 * load/store unit top
 */

module load_store_unit #(
  parameter int unsigned MAX_OUTSTANDING = lsu_pkg::DEFAULT_DEPTH
) (
  input  logic                clk,
  input  logic                rst_n,
  // EX stage
  input  logic                data_req_ex_i,
  input  logic                data_we_ex_i,
  input  lsu_pkg::data_type_e data_type_ex_i,
  input  lsu_pkg::sign_ext_e  data_sign_ext_ex_i,
  input  lsu_pkg::word_t      data_wdata_ex_i,
  input  logic [1:0]          data_reg_offset_ex_i,
  input  lsu_pkg::word_t      operand_a_ex_i,
  input  lsu_pkg::word_t      operand_b_ex_i,
  input  logic                addr_useincr_ex_i,
  input  logic                data_misaligned_ex_i,
  output lsu_pkg::word_t      data_rdata_ex_o,
  output logic                data_misaligned_o,
  output logic                lsu_ready_ex_o,
  output logic                lsu_ready_wb_o,
  output logic                busy_o,
  // memory bus
  output logic                data_req_o,
  output lsu_pkg::word_t      data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::word_t      data_wdata_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  lsu_pkg::word_t      data_rdata_i
);

  logic       trans_valid;  // request toward the bus
  logic       trans_ready;  // bus accepted it
  logic       ctrl_update;  // access advances to WB
  logic [1:0] addr_lsb;     // byte offset for load alignment

  // transaction inputs are stable until grant, so the bus side is plain wiring
  assign data_req_o  = trans_valid;
  assign trans_ready = data_gnt_i;
  assign data_we_o   = data_we_ex_i;

  lsu_request lsu_request_i (
    .data_type_ex_i       (data_type_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_req_ex_i        (data_req_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .bus_addr_o           (data_addr_o),
    .bus_be_o             (data_be_o),
    .bus_wdata_o          (data_wdata_o),
    .addr_lsb_o           (addr_lsb),
    .data_misaligned_o    (data_misaligned_o)
  );

  lsu_txn_ctrl #(
    .DEPTH (MAX_OUTSTANDING)
  ) lsu_txn_ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .gnt_i          (trans_ready),
    .rvalid_i       (data_rvalid_i),
    .trans_valid_o  (trans_valid),
    .ctrl_update_o  (ctrl_update),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  lsu_load_align lsu_load_align_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .addr_lsb_i           (addr_lsb),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .rvalid_i             (data_rvalid_i),
    .rdata_i              (data_rdata_i),
    .data_rdata_ex_o      (data_rdata_ex_o)
  );

endmodule

// ==== hdl/lsu_load_align.sv ====
/*
 * lsu load alignment and extension
 */

module lsu_load_align (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ctrl_update_i,         // access moves to WB
  input  lsu_pkg::data_type_e data_type_ex_i,
  input  lsu_pkg::sign_ext_e  data_sign_ext_ex_i,
  input  logic                data_we_ex_i,
  input  logic [1:0]          addr_lsb_i,            // byte offset of the access
  input  logic                data_misaligned_ex_i,  // second phase in EX
  input  logic                data_misaligned_i,     // first phase of a split in EX
  input  logic                rvalid_i,
  input  lsu_pkg::word_t      rdata_i,
  output lsu_pkg::word_t      data_rdata_ex_o        // load result
);

  import lsu_pkg::*;

  data_type_e data_type_q;     // attributes of the access in WB
  sign_ext_e  data_sign_ext_q;
  logic [1:0] rdata_offset_q;
  logic       data_we_q;

  word_t       rdata_q;        // partial word or last result
  word_t       rdata_w_asm;    // word, assembled across two responses
  logic [15:0] rdata_h_raw;    // selected half before extension
  logic [7:0]  rdata_b_raw;    // selected byte before extension
  word_t       rdata_ext;      // final result

  // extend a narrow value, half selects a 16-bit width, else 8-bit
  function automatic word_t fill_ext(input word_t val, input logic half, input sign_ext_e mode);
    word_t mask;
    logic  msb;
    logic  fill;
    mask = half ? word_t'(16'hffff) : word_t'(8'hff);
    msb  = half ? val[15] : val[7];
    case (mode)
      SE_ZERO: fill = 1'b0;
      SE_ONES: fill = 1'b1;
      default: fill = msb;  // SE_SIGN, SE_SIGN_ALT
    endcase
    return (val & mask) | ({DATA_W{fill}} & ~mask);
  endfunction

  //////////////////////////////////////////////////
  // response-side control registers
  //////////////////////////////////////////////////

  // hold between accesses so a late rvalid still sees its own attributes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_type_q     <= DT_WORD;
      data_sign_ext_q <= SE_ZERO;
      rdata_offset_q  <= 2'b00;
      data_we_q       <= 1'b0;
    end else if (ctrl_update_i) begin
      data_type_q     <= data_type_ex_i;
      data_sign_ext_q <= data_sign_ext_ex_i;
      rdata_offset_q  <= addr_lsb_i;
      data_we_q       <= data_we_ex_i;
    end
  end

  //////////////////////////////////////////////////
  // lane select and extension
  //////////////////////////////////////////////////

  // upper bytes from the first response, lower bytes from the second
  always_comb begin
    case (rdata_offset_q)
      2'b00:   rdata_w_asm = rdata_i;
      2'b01:   rdata_w_asm = {rdata_i[7:0], rdata_q[31:8]};
      2'b10:   rdata_w_asm = {rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w_asm = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (rdata_offset_q)
      2'b00:   rdata_h_raw = rdata_i[15:0];
      2'b01:   rdata_h_raw = rdata_i[23:8];
      2'b10:   rdata_h_raw = rdata_i[31:16];
      default: rdata_h_raw = {rdata_i[7:0], rdata_q[31:24]};  // split half
    endcase
  end

  assign rdata_b_raw = rdata_i[8*rdata_offset_q +: 8];

  always_comb begin
    case (data_type_q)
      DT_WORD: rdata_ext = rdata_w_asm;
      DT_HALF: rdata_ext = fill_ext(word_t'(rdata_h_raw), 1'b1, data_sign_ext_q);
      default: rdata_ext = fill_ext(word_t'(rdata_b_raw), 1'b0, data_sign_ext_q);
    endcase
  end

  // partial register, raw word mid-split, else the finished result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rvalid_i && !data_we_q) begin
      if (data_misaligned_ex_i || data_misaligned_i) begin
        rdata_q <= rdata_i;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  assign data_rdata_ex_o = rvalid_i ? rdata_ext : rdata_q;  // last value between responses

endmodule

// ==== hdl/lsu_txn_ctrl.sv ====
/*
 * lsu transaction control
 */

module lsu_txn_ctrl #(
  parameter int unsigned DEPTH = lsu_pkg::DEFAULT_DEPTH  // max outstanding accesses
) (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // EX stage wants an access
  input  logic gnt_i,           // bus accepted the request
  input  logic rvalid_i,        // response for the oldest access
  output logic trans_valid_o,   // request to the bus
  output logic ctrl_update_o,   // load response-side attributes
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEPTH);

  logic [CNT_W-1:0] cnt_q;       // accesses accepted but not yet answered
  logic [CNT_W-1:0] cnt_d;
  logic             count_up;    // accept this cycle
  logic             count_down;  // response this cycle

  // no new request once the limit is reached
  assign trans_valid_o = data_req_ex_i && (cnt_q < CNT_MAX);

  assign count_up   = trans_valid_o && gnt_i;
  assign count_down = rvalid_i;

  //////////////////////////////////////////////////
  // outstanding counter
  //////////////////////////////////////////////////

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // idle, or accept and response cancel out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////
  // stage readiness
  //////////////////////////////////////////////////

  // WB is free when nothing is in flight, else when the awaited response shows up
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : rvalid_i;

  // EX moves on together with WB when something is already in flight
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;                  // nothing to do
    end else if (cnt_q == '0) begin
      lsu_ready_ex_o = count_up;              // empty, accept is enough
    end else if (cnt_q < CNT_MAX) begin
      lsu_ready_ex_o = count_up && rvalid_i;  // accept while WB drains
    end else begin
      lsu_ready_ex_o = rvalid_i;              // full, wait for a response
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;

  assign busy_o = (cnt_q != '0) || trans_valid_o;  // in flight or being requested

endmodule

// ==== hdl/lsu_request.sv ====
/*
 * lsu request side
 */

module lsu_request (
  input  lsu_pkg::data_type_e data_type_ex_i,        // access size
  input  lsu_pkg::word_t      data_wdata_ex_i,       // store data from register file
  input  logic [1:0]          data_reg_offset_ex_i,  // byte offset inside the register
  input  lsu_pkg::word_t      operand_a_ex_i,        // base
  input  lsu_pkg::word_t      operand_b_ex_i,        // increment
  input  logic                addr_useincr_ex_i,     // a + b when set, else a
  input  logic                data_req_ex_i,
  input  logic                data_misaligned_ex_i,  // second phase of a split access
  output lsu_pkg::word_t      bus_addr_o,
  output lsu_pkg::be_t        bus_be_o,
  output lsu_pkg::word_t      bus_wdata_o,
  output logic [1:0]          addr_lsb_o,            // byte offset for the response side
  output logic                data_misaligned_o      // a second access is needed
);

  import lsu_pkg::*;

  word_t      addr_int;      // effective byte address
  logic [1:0] wdata_offset;  // byte rotation for store data

  // effective address
  assign addr_int   = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign addr_lsb_o = addr_int[1:0];

  // second phase always starts at lane 0 of the next word
  assign bus_addr_o = data_misaligned_ex_i ? {addr_int[ADDR_W-1:2], 2'b00} : addr_int;

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    case (data_type_ex_i)
      DT_WORD: begin
        if (!data_misaligned_ex_i) begin
          bus_be_o = be_t'(4'b1111) << addr_int[1:0];  // lanes from offset up
        end else begin
          // remaining lanes below the offset
          bus_be_o = (be_t'(4'b0001) << addr_int[1:0]) - be_t'(4'b0001);
        end
      end
      DT_HALF: begin
        if (!data_misaligned_ex_i) begin
          bus_be_o = be_t'(4'b0011) << addr_int[1:0];  // lane 3 only at offset 3
        end else begin
          bus_be_o = 4'b0001;  // high byte of the split half
        end
      end
      default: bus_be_o = be_t'(4'b0001) << addr_int[1:0];  // DT_BYTE, DT_BYTE_ALT
    endcase
  end

  //////////////////////////////////////////////////
  // store data lane rotation
  //////////////////////////////////////////////////

  // rotate left one byte per unit, wraps mod 4
  assign wdata_offset = addr_int[1:0] - data_reg_offset_ex_i;

  always_comb begin
    case (wdata_offset)
      2'b00:   bus_wdata_o = data_wdata_ex_i;
      2'b01:   bus_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'b10:   bus_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: bus_wdata_o = {data_wdata_ex_i[7:0], data_wdata_ex_i[31:8]};
    endcase
  end

  // misalignment check, only on a fresh first phase
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      case (data_type_ex_i)
        DT_WORD: data_misaligned_o = (addr_int[1:0] != 2'b00);  // any nonzero offset
        DT_HALF: data_misaligned_o = (addr_int[1:0] == 2'b11);  // crosses into next word
        default: data_misaligned_o = 1'b0;                       // bytes never split
      endcase
    end
  end

endmodule

// ==== hdl/lsu_pkg.sv ====
/*
 * load/store unit shared types
 */

package lsu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // byte-lane logic is written for a 32-bit word, so these stay fixed
  localparam int unsigned ADDR_W = 32;  // byte address
  localparam int unsigned DATA_W = 32;  // bus data word
  localparam int unsigned BE_W   = 4;   // one enable per byte lane

  // outstanding-transaction limit unless the top level overrides it
  localparam int unsigned DEFAULT_DEPTH = 2;

  typedef logic [DATA_W-1:0] word_t;  // address or data word
  typedef logic [BE_W-1:0]   be_t;    // byte-lane enables

  //////////////////////////////////////////////////
  // access attributes from the EX stage
  //////////////////////////////////////////////////

  // access size, both byte codes select a single byte
  typedef enum logic [1:0] {
    DT_WORD     = 2'b00,
    DT_HALF     = 2'b01,
    DT_BYTE     = 2'b10,
    DT_BYTE_ALT = 2'b11
  } data_type_e;

  // fill mode for the upper bits of a narrow load
  typedef enum logic [1:0] {
    SE_ZERO     = 2'b00,  // zero fill
    SE_SIGN     = 2'b01,  // copy lane msb
    SE_ONES     = 2'b10,  // ones fill
    SE_SIGN_ALT = 2'b11   // same as SE_SIGN
  } sign_ext_e;

endpackage
